// File: include/pipeline_ctrl_config.svh
`ifndef PIPELINE_CTRL_CONFIG_SVH
`define PIPELINE_CTRL_CONFIG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Register file address width
`define REG_ADDR_W 5

// PC and data word width
`define XLEN 32

////////////////////////////////////////
// Exception handling
////////////////////////////////////////

// Common handler entry for syscall and interrupt
`define EXC_VECTOR 32'h80000180

`endif

// File: src/pipeline_ctrl_pkg.sv
package pipeline_ctrl_pkg;

	////////////////////////////////////////
	// Next-PC source select
	////////////////////////////////////////

	// Encodings match the fetch stage PC mux
	typedef enum logic [3:0]
	{
		PC_JUMP   = 4'd0,
		PC_JR     = 4'd1,
		PC_EXC    = 4'd2,
		PC_ERET   = 4'd3,
		PC_BR_FIX = 4'd4,
		PC_SEQ    = 4'd5
	} pc_src_e;

	////////////////////////////////////////
	// CP0 cause codes
	////////////////////////////////////////

	// Only the two supported causes
	typedef enum logic [4:0]
	{
		EXC_INT = 5'd0,
		EXC_SYS = 5'd8
	} exc_code_e;

endpackage

// File: src/ctrl_ifs.sv
`include "pipeline_ctrl_config.svh"

////////////////////////////////////////
// Hazard status
////////////////////////////////////////

interface hazard_if;

	// Memory stall level
	logic hold;
	// Gated hazards, already prioritized
	logic load_use;
	logic mispredict;
	// Misprediction before the hold gate, for EPC choice
	logic raw_mispredict;

	modport src (output hold, output load_use, output mispredict, output raw_mispredict);
	modport sink (input hold, input load_use, input mispredict, input raw_mispredict);

endinterface

////////////////////////////////////////
// Exception decision
////////////////////////////////////////

interface exc_if;

	import pipeline_ctrl_pkg::*;

	logic exc_take;
	exc_code_e exc_code;
	logic [`XLEN-1:0] exc_epc;
	logic eret_take;

	modport src (output exc_take, output exc_code, output exc_epc, output eret_take);
	modport sink (input exc_take, input exc_code, input exc_epc, input eret_take);

endinterface

// File: src/hazard_detector.sv
`include "pipeline_ctrl_config.svh"

module hazard_detector
(
	input logic mem_stall,
	input logic [`REG_ADDR_W-1:0] id_rs_addr,
	input logic [`REG_ADDR_W-1:0] id_rt_addr,
	input logic [`REG_ADDR_W-1:0] ex_rd_addr,
	input logic ex_mem_read,
	input logic [`XLEN-1:0] predicted_ex_pc,
	input logic [`XLEN-1:0] target_mem_pc,
	hazard_if.src haz
);

	logic load_hit;
	logic pc_miss;

	// Load in EX feeding either source of the instruction in ID
	assign load_hit = ex_mem_read &
		((ex_rd_addr == id_rs_addr) | (ex_rd_addr == id_rt_addr));

	// Resolved PC in MEM disagrees with what was fetched behind it
	assign pc_miss = predicted_ex_pc != target_mem_pc;

	////////////////////////////////////////
	// Gating
	////////////////////////////////////////

	always_comb
	begin
		haz.hold = mem_stall;
		haz.raw_mispredict = pc_miss;
		// Nothing acts while memory holds the pipe
		haz.mispredict = pc_miss & ~mem_stall;
		// A misprediction flushes the load anyway
		haz.load_use = load_hit & ~pc_miss & ~mem_stall;
	end

	// Control merge relies on at most one of these per cycle
	always_comb
	begin
		assert (!(haz.load_use && haz.mispredict))
		else
			$error("load_use and mispredict both high");
	end

endmodule

// File: src/exception_unit.sv
`include "pipeline_ctrl_config.svh"

module exception_unit
(
	input logic clk,
	input logic arst_n,
	input logic cp0_intr,
	input logic mem_syscall,
	input logic mem_eret,
	input logic [`XLEN-1:0] predicted_ex_pc,
	input logic [`XLEN-1:0] target_mem_pc,
	hazard_if.sink haz,
	exc_if.src exc,
	output logic [`XLEN-1:0] epc
);

	import pipeline_ctrl_pkg::*;

	logic exl_q;
	logic [`XLEN-1:0] epc_q;
	logic intr_ok;
	logic eret_go;
	logic exc_go;

	////////////////////////////////////////
	// Event decisions
	////////////////////////////////////////

	// Interrupts are masked inside the handler
	assign intr_ok = cp0_intr & ~exl_q;

	// Return only from a correctly predicted path
	assign eret_go = mem_eret & ~haz.hold & ~haz.mispredict;

	// An eret in the same cycle wins
	assign exc_go = (mem_syscall | intr_ok) & ~haz.hold & ~eret_go;

	always_comb
	begin
		exc.exc_take = exc_go;
		exc.eret_take = eret_go;

		// Interrupt has precedence over syscall
		if (intr_ok)
			exc.exc_code = EXC_INT;
		else
			exc.exc_code = EXC_SYS;

		// On a wrong path the interrupt resumes at the corrected PC
		if (intr_ok && haz.raw_mispredict)
			exc.exc_epc = target_mem_pc;
		else
			exc.exc_epc = predicted_ex_pc;
	end

	////////////////////////////////////////
	// Exception level and saved EPC
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exl_q <= 1'b0;
		end
		else if (exc_go)
		begin
			exl_q <= 1'b1;
		end
		else if (eret_go)
		begin
			exl_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			epc_q <= '0;
		else if (exc_go)
			epc_q <= exc.exc_epc;
	end

	// Return address for eret
	assign epc = epc_q;

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_exc_eret_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(exc.exc_take && exc.eret_take));

endmodule

// File: src/control_unit.sv
`include "pipeline_ctrl_config.svh"

module control_unit
(
	input logic id_jump,
	input logic id_jr,
	hazard_if.sink haz,
	exc_if.sink exc,
	output pipeline_ctrl_pkg::pc_src_e pc_src,
	output logic pc_stall,
	output logic ifid_stall,
	output logic idex_stall,
	output logic exmem_stall,
	output logic ifid_flush,
	output logic idex_flush,
	output logic exmem_flush,
	output logic cp0_w_en,
	output pipeline_ctrl_pkg::exc_code_e exec_code,
	output logic [`XLEN-1:0] cp0_epc,
	output logic bpu_write_en
);

	import pipeline_ctrl_pkg::*;

	////////////////////////////////////////
	// Priority merge, later rules win
	////////////////////////////////////////

	always_comb
	begin
		// Idle: fall through to the next sequential PC
		pc_src = PC_SEQ;
		pc_stall = 1'b0;
		ifid_stall = 1'b0;
		idex_stall = 1'b0;
		exmem_stall = 1'b0;
		ifid_flush = 1'b0;
		idex_flush = 1'b0;
		exmem_flush = 1'b0;
		cp0_w_en = 1'b0;
		exec_code = EXC_INT;
		cp0_epc = '0;
		bpu_write_en = 1'b0;

		// Memory hold freezes every stage
		if (haz.hold)
		begin
			pc_stall = 1'b1;
			ifid_stall = 1'b1;
			idex_stall = 1'b1;
			exmem_stall = 1'b1;
		end

		// Load-use: keep ID, insert a bubble into EX
		if (haz.load_use)
		begin
			pc_stall = 1'b1;
			ifid_stall = 1'b1;
			idex_flush = 1'b1;
		end

		// Wrong path: drop the three younger stages and retrain
		if (haz.mispredict)
		begin
			ifid_flush = 1'b1;
			idex_flush = 1'b1;
			exmem_flush = 1'b1;
			bpu_write_en = 1'b1;
			if (!exc.exc_take)
				pc_src = PC_BR_FIX;
		end

		if (!haz.hold && !haz.mispredict && id_jump)
		begin
			pc_src = PC_JUMP;
			ifid_flush = 1'b1;
		end

		// jr decoded after jump so it overrides
		if (!haz.hold && !haz.mispredict && id_jr)
		begin
			pc_src = PC_JR;
			ifid_flush = 1'b1;
		end

		if (exc.exc_take)
		begin
			pc_src = PC_EXC;
			cp0_w_en = 1'b1;
			exec_code = exc.exc_code;
			cp0_epc = exc.exc_epc;
		end

		if (exc.eret_take)
			pc_src = PC_ERET;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Hold gating is spread over hazard_detector and exception_unit
	always_comb
	begin
		assert (!(haz.hold && (ifid_flush || idex_flush || exmem_flush)))
		else
			$error("flush raised during memory hold");
	end

endmodule

// File: src/pipeline_ctrl.sv
`include "pipeline_ctrl_config.svh"

module pipeline_ctrl
(
	input logic clk,
	input logic arst_n,
	// Decode stage
	input logic id_jump,
	input logic id_jr,
	input logic [`REG_ADDR_W-1:0] id_rs_addr,
	input logic [`REG_ADDR_W-1:0] id_rt_addr,
	// Execute stage
	input logic [`REG_ADDR_W-1:0] ex_rd_addr,
	input logic ex_mem_read,
	input logic [`XLEN-1:0] predicted_ex_pc,
	// Memory stage
	input logic mem_stall,
	input logic [`XLEN-1:0] target_mem_pc,
	input logic mem_syscall,
	input logic mem_eret,
	input logic cp0_intr,
	// Pipeline control
	output pipeline_ctrl_pkg::pc_src_e pc_src,
	output logic pc_stall,
	output logic ifid_stall,
	output logic idex_stall,
	output logic exmem_stall,
	output logic ifid_flush,
	output logic idex_flush,
	output logic exmem_flush,
	// CP0 and predictor
	output logic cp0_w_en,
	output pipeline_ctrl_pkg::exc_code_e exec_code,
	output logic [`XLEN-1:0] cp0_epc,
	output logic [`XLEN-1:0] epc,
	output logic bpu_write_en
);

	hazard_if haz_bus ();
	exc_if exc_bus ();

	////////////////////////////////////////
	// Detection and exception decision
	////////////////////////////////////////

	hazard_detector u_hazard_detector
	(
		.mem_stall(mem_stall),
		.id_rs_addr(id_rs_addr),
		.id_rt_addr(id_rt_addr),
		.ex_rd_addr(ex_rd_addr),
		.ex_mem_read(ex_mem_read),
		.predicted_ex_pc(predicted_ex_pc),
		.target_mem_pc(target_mem_pc),
		.haz(haz_bus.src)
	);

	exception_unit u_exception_unit
	(
		.clk(clk),
		.arst_n(arst_n),
		.cp0_intr(cp0_intr),
		.mem_syscall(mem_syscall),
		.mem_eret(mem_eret),
		.predicted_ex_pc(predicted_ex_pc),
		.target_mem_pc(target_mem_pc),
		.haz(haz_bus.sink),
		.exc(exc_bus.src),
		.epc(epc)
	);

	// Merge
	control_unit u_control_unit
	(
		.id_jump(id_jump),
		.id_jr(id_jr),
		.haz(haz_bus.sink),
		.exc(exc_bus.sink),
		.pc_src(pc_src),
		.pc_stall(pc_stall),
		.ifid_stall(ifid_stall),
		.idex_stall(idex_stall),
		.exmem_stall(exmem_stall),
		.ifid_flush(ifid_flush),
		.idex_flush(idex_flush),
		.exmem_flush(exmem_flush),
		.cp0_w_en(cp0_w_en),
		.exec_code(exec_code),
		.cp0_epc(cp0_epc),
		.bpu_write_en(bpu_write_en)
	);

endmodule

// File: tests/pipeline_ctrl_tb.sv
`include "pipeline_ctrl_config.svh"

module pipeline_ctrl_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import pipeline_ctrl_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int NUM_CYCLES = 2000;
	// Random run plus a quarter for reset and slack
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;
	localparam logic [31:0] LFSR_SEED = 32'h3b492ce9;

	logic clk;
	logic arst_n;
	logic id_jump;
	logic id_jr;
	logic [`REG_ADDR_W-1:0] id_rs_addr;
	logic [`REG_ADDR_W-1:0] id_rt_addr;
	logic [`REG_ADDR_W-1:0] ex_rd_addr;
	logic ex_mem_read;
	logic [`XLEN-1:0] predicted_ex_pc;
	logic mem_stall;
	logic [`XLEN-1:0] target_mem_pc;
	logic mem_syscall;
	logic mem_eret;
	logic cp0_intr;
	pc_src_e pc_src;
	logic pc_stall;
	logic ifid_stall;
	logic idex_stall;
	logic exmem_stall;
	logic ifid_flush;
	logic idex_flush;
	logic exmem_flush;
	logic cp0_w_en;
	exc_code_e exec_code;
	logic [`XLEN-1:0] cp0_epc;
	logic [`XLEN-1:0] epc;
	logic bpu_write_en;

	// Reference model state and per-cycle decisions
	logic m_exl;
	logic [`XLEN-1:0] m_epc;
	logic m_exc;
	logic m_eret;
	logic m_hold;
	logic m_mis;
	logic m_lu;
	exc_code_e m_code;
	logic [`XLEN-1:0] m_exc_epc;
	pc_src_e e_pc_src;

	logic [31:0] lfsr;
	int errors;
	int checks;
	int cycle_cnt;
	int n_hold;
	int n_load_use;
	int n_mispredict;
	int n_exc;
	int n_eret;

	pipeline_ctrl dut_i
	(
		.clk(clk), .arst_n(arst_n), .id_jump(id_jump), .id_jr(id_jr),
		.id_rs_addr(id_rs_addr), .id_rt_addr(id_rt_addr), .ex_rd_addr(ex_rd_addr),
		.ex_mem_read(ex_mem_read), .predicted_ex_pc(predicted_ex_pc),
		.mem_stall(mem_stall), .target_mem_pc(target_mem_pc),
		.mem_syscall(mem_syscall), .mem_eret(mem_eret), .cp0_intr(cp0_intr),
		.pc_src(pc_src), .pc_stall(pc_stall), .ifid_stall(ifid_stall),
		.idex_stall(idex_stall), .exmem_stall(exmem_stall), .ifid_flush(ifid_flush),
		.idex_flush(idex_flush), .exmem_flush(exmem_flush), .cp0_w_en(cp0_w_en),
		.exec_code(exec_code), .cp0_epc(cp0_epc), .epc(epc), .bpu_write_en(bpu_write_en)
	);

	always #2 clk = ~clk;

	// Hard stop in case the main sequence never reaches its end
	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic drive_idle_inputs();
		id_jump = 1'b0;
		id_jr = 1'b0;
		id_rs_addr = '0;
		id_rt_addr = '0;
		ex_rd_addr = '0;
		ex_mem_read = 1'b0;
		predicted_ex_pc = '0;
		target_mem_pc = '0;
		mem_stall = 1'b0;
		mem_syscall = 1'b0;
		mem_eret = 1'b0;
		cp0_intr = 1'b0;
	endtask

	task automatic drive_random_inputs();
		// 2-bit register numbers so that matches happen often
		id_rs_addr = `REG_ADDR_W'(take_bits(2));
		id_rt_addr = `REG_ADDR_W'(take_bits(2));
		ex_rd_addr = `REG_ADDR_W'(take_bits(2));
		ex_mem_read = take_bits(1) == 32'd1;
		predicted_ex_pc = take_bits(32);
		if (take_bits(2) == 32'd0)
			target_mem_pc = take_bits(32);
		else
			target_mem_pc = predicted_ex_pc;
		// Rare events at one in eight each
		mem_stall = take_bits(3) == 32'd0;
		id_jump = take_bits(3) == 32'd0;
		id_jr = take_bits(3) == 32'd0;
		mem_syscall = take_bits(3) == 32'd0;
		mem_eret = take_bits(3) == 32'd0;
		cp0_intr = take_bits(3) == 32'd0;
	endtask

	////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////

	task automatic predict_outputs();
		logic raw_mis;
		logic intr;
		raw_mis = predicted_ex_pc != target_mem_pc;
		m_hold = mem_stall;
		m_mis = raw_mis && !m_hold;
		m_lu = ex_mem_read && !m_hold && !raw_mis &&
			(ex_rd_addr == id_rs_addr || ex_rd_addr == id_rt_addr);
		m_eret = mem_eret && !m_hold && !m_mis;
		// Interrupt masked while in the handler
		intr = cp0_intr && !m_exl;
		m_exc = (mem_syscall || intr) && !m_hold && !m_eret;
		m_code = intr ? EXC_INT : EXC_SYS;
		m_exc_epc = (intr && raw_mis) ? target_mem_pc : predicted_ex_pc;
		// Highest priority first
		if (m_eret)
			e_pc_src = PC_ERET;
		else if (m_exc)
			e_pc_src = PC_EXC;
		else if (!m_hold && !m_mis && id_jr)
			e_pc_src = PC_JR;
		else if (!m_hold && !m_mis && id_jump)
			e_pc_src = PC_JUMP;
		else if (m_mis)
			e_pc_src = PC_BR_FIX;
		else
			e_pc_src = PC_SEQ;
	endtask

	task automatic compare_output(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic jump_ok;
		jump_ok = !m_hold && !m_mis && (id_jump || id_jr);
		compare_output("pc_src", 32'(pc_src), 32'(e_pc_src));
		compare_output("pc_stall", 32'(pc_stall), 32'(m_hold || m_lu));
		compare_output("ifid_stall", 32'(ifid_stall), 32'(m_hold || m_lu));
		compare_output("idex_stall", 32'(idex_stall), 32'(m_hold));
		compare_output("exmem_stall", 32'(exmem_stall), 32'(m_hold));
		compare_output("ifid_flush", 32'(ifid_flush), 32'(m_mis || jump_ok));
		compare_output("idex_flush", 32'(idex_flush), 32'(m_mis || m_lu));
		compare_output("exmem_flush", 32'(exmem_flush), 32'(m_mis));
		compare_output("bpu_write_en", 32'(bpu_write_en), 32'(m_mis));
		compare_output("cp0_w_en", 32'(cp0_w_en), 32'(m_exc));
		compare_output("exec_code", 32'(exec_code), m_exc ? 32'(m_code) : 32'(EXC_INT));
		compare_output("cp0_epc", cp0_epc, m_exc ? m_exc_epc : 32'd0);
		compare_output("epc", epc, m_epc);
	endtask

	// Exl and saved EPC follow the event taken at the rising edge
	task automatic update_model();
		n_hold += int'(m_hold);
		n_load_use += int'(m_lu);
		n_mispredict += int'(m_mis);
		n_exc += int'(m_exc);
		n_eret += int'(m_eret);
		if (m_exc)
		begin
			m_exl = 1'b1;
			m_epc = m_exc_epc;
		end
		else if (m_eret)
			m_exl = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		drive_idle_inputs();
		lfsr = LFSR_SEED;
		m_exl = 1'b0;
		m_epc = '0;
		errors = 0;
		checks = 0;
		cycle_cnt = 0;
		n_hold = 0;
		n_load_use = 0;
		n_mispredict = 0;
		n_exc = 0;
		n_eret = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		// Idle cycle straight out of reset
		#1;
		predict_outputs();
		check_outputs();
		@(posedge clk);
		update_model();
		for (int i = 0; i < NUM_CYCLES; i++)
		begin
			@(negedge clk);
			drive_random_inputs();
			#1;
			predict_outputs();
			check_outputs();
			@(posedge clk);
			update_model();
		end
		if (n_hold == 0 || n_load_use == 0 || n_mispredict == 0 ||
			n_exc == 0 || n_eret == 0)
		begin
			$display("Random stimulus left at least one event class unexercised");
			errors++;
		end
		$write("Cycles %0d, checks %0d, hold %0d, load-use %0d, ",
			cycle_cnt, checks, n_hold, n_load_use);
		$display("mispredict %0d, exc %0d, eret %0d, errors %0d",
			n_mispredict, n_exc, n_eret, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: pipeline_ctrl.f
+incdir+include
src/pipeline_ctrl_pkg.sv
src/ctrl_ifs.sv
src/hazard_detector.sv
src/exception_unit.sv
src/control_unit.sv
src/pipeline_ctrl.sv
tests/pipeline_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pipeline control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pipeline_ctrl.f \
	--top-module pipeline_ctrl_tb -o pipeline_ctrl_sim || exit 1

sim_out=$(./obj_dir/pipeline_ctrl_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
